// File: src/uart_defs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// Clock cycles per quarter-bit tick
// 4 here gives a 16 clock bit period in simulation
// Any value of 2 or more is valid
`define UART_CLK_DIV 4

// Ticks per serial bit period
// The receiver samples at tick 2 of the start bit and then every 4 ticks
`define UART_TICKS_PER_BIT 4

// Ticks the receiver ignores the line after a framing error
// Two bit periods
`define UART_HOLDOFF_TICKS 8

// Data bits per frame, sent least significant bit first
`define UART_DATA_BITS 8

`endif

// File: src/uart_pkg.sv
`include "uart_defs.svh"

package uart_pkg;

	// Transmit request from the parallel side
	// send is a one-cycle strobe, ignored while the transmitter is busy
	typedef struct packed {
		logic                        send;
		logic [`UART_DATA_BITS-1:0]  data;
	} tx_req_t;

	// Receive result
	// received and error are one-cycle pulses
	// data holds the last good byte until the next frame completes
	typedef struct packed {
		logic                        received;
		logic                        error;
		logic [`UART_DATA_BITS-1:0]  data;
	} rx_event_t;

	// Line activity flags, high while a frame is in progress
	typedef struct packed {
		logic receiving;
		logic transmitting;
	} line_status_t;

	// Receiver FSM
	typedef enum logic [2:0] {
		rx_idle,
		rx_check_start,
		rx_read_bits,
		rx_check_stop,
		rx_received,
		rx_error,
		rx_holdoff
	} rx_state_e;

	// Transmitter FSM
	typedef enum logic [1:0] {
		tx_idle,
		tx_sending,
		tx_stop
	} tx_state_e;

endpackage

// File: src/uart_rx.sv
`timescale 1ns/100ps

`include "uart_defs.svh"

module uart_rx (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 rx,
	output uart_pkg::rx_event_t  rx_evt,
	output logic                 receiving
);

	import uart_pkg::*;

	// Divider and countdown widths
	localparam int div_w = $clog2(`UART_CLK_DIV);
	localparam int cnt_w = $clog2(`UART_HOLDOFF_TICKS + 1);
	localparam int bit_w = $clog2(`UART_DATA_BITS + 1);

	// Reload values for the tick countdown
	localparam logic [cnt_w-1:0] half_ticks    = cnt_w'(`UART_TICKS_PER_BIT / 2);
	localparam logic [cnt_w-1:0] bit_ticks     = cnt_w'(`UART_TICKS_PER_BIT);
	localparam logic [cnt_w-1:0] holdoff_ticks = cnt_w'(`UART_HOLDOFF_TICKS);

	rx_state_e state;

	// Two-flop synchronizer, both stages idle high
	logic rx_meta;
	logic rx_sync;

	// Quarter-bit divider
	logic [div_w-1:0] clk_cnt;
	logic             tick;
	logic             div_restart;

	// Ticks left in the current wait, bits left in the frame
	logic [cnt_w-1:0] tick_cnt;
	logic             tick_done;
	logic [bit_w-1:0] bit_cnt;

	// Incoming bits and the last good byte
	logic [`UART_DATA_BITS-1:0] shift_q;
	logic [`UART_DATA_BITS-1:0] byte_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	// Realign on the falling start edge so ticks land mid-bit,
	// and again on error so the holdoff is a full 8 ticks
	assign div_restart = ((state == rx_idle) && !rx_sync) || (state == rx_error);
	assign tick = (clk_cnt == div_w'(`UART_CLK_DIV - 1));

	always_ff @(posedge clk) begin
		if (rst || div_restart || tick) begin
			clk_cnt <= '0;
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// Last tick of the current wait
	assign tick_done = tick && (tick_cnt == cnt_w'(1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= rx_idle;
			tick_cnt <= '0;
			bit_cnt  <= '0;
		end else begin
			// Countdown runs on its own, states reload it
			if (tick && (tick_cnt != '0)) begin
				tick_cnt <= tick_cnt - 1'b1;
			end
			case (state)
				rx_idle: begin
					// First low sample, wait half a bit
					if (!rx_sync) begin
						tick_cnt <= half_ticks;
						state    <= rx_check_start;
					end
				end
				rx_check_start: begin
					if (tick_done) begin
						// Start bit must still be low at its middle
						if (!rx_sync) begin
							tick_cnt <= bit_ticks;
							bit_cnt  <= bit_w'(`UART_DATA_BITS);
							state    <= rx_read_bits;
						end else begin
							state <= rx_error;
						end
					end
				end
				rx_read_bits: begin
					if (tick_done) begin
						tick_cnt <= bit_ticks;
						bit_cnt  <= bit_cnt - 1'b1;
						if (bit_cnt == bit_w'(1)) begin
							state <= rx_check_stop;
						end
					end
				end
				rx_check_stop: begin
					// Stop bit low means a broken frame
					if (tick_done) begin
						state <= rx_sync ? rx_received : rx_error;
					end
				end
				rx_received: begin
					state <= rx_idle;
				end
				rx_error: begin
					tick_cnt <= holdoff_ticks;
					state    <= rx_holdoff;
				end
				rx_holdoff: begin
					// Line ignored until the holdoff runs out
					if (tick_done) begin
						state <= rx_idle;
					end
				end
				default: begin
					state <= rx_idle;
				end
			endcase
		end
	end

	// Data enters from the top so the first bit ends up in bit 0
	always_ff @(posedge clk) begin
		if ((state == rx_read_bits) && tick_done) begin
			shift_q <= {rx_sync, shift_q[`UART_DATA_BITS-1:1]};
		end
		if ((state == rx_check_stop) && tick_done && rx_sync) begin
			byte_q <= shift_q;
		end
	end

	// Strobes decoded from one-cycle states
	assign rx_evt.received = (state == rx_received);
	assign rx_evt.error    = (state == rx_error);
	assign rx_evt.data     = byte_q;
	assign receiving       = (state != rx_idle);

endmodule

// File: src/uart_tx.sv
`timescale 1ns/100ps

`include "uart_defs.svh"

module uart_tx (
	input  logic               clk,
	input  logic               rst,
	input  uart_pkg::tx_req_t  tx_req,
	output logic               tx,
	output logic               transmitting
);

	import uart_pkg::*;

	// Two stop bits are sent as one long wait
	localparam int stop_ticks = 2 * `UART_TICKS_PER_BIT;
	localparam int div_w      = $clog2(`UART_CLK_DIV);
	localparam int cnt_w      = $clog2(stop_ticks + 1);
	localparam int bit_w      = $clog2(`UART_DATA_BITS + 1);

	localparam logic [cnt_w-1:0] bit_ticks  = cnt_w'(`UART_TICKS_PER_BIT);
	localparam logic [cnt_w-1:0] stop_count = cnt_w'(stop_ticks);

	tx_state_e state;

	// Quarter-bit divider
	logic [div_w-1:0] clk_cnt;
	logic             tick;

	// Wait countdown and data bits still to send
	logic [cnt_w-1:0] tick_cnt;
	logic             tick_done;
	logic [bit_w-1:0] bit_cnt;

	logic                       accept;
	logic                       tx_q;
	logic [`UART_DATA_BITS-1:0] data_q;

	// Request only taken while idle, otherwise dropped
	assign accept = tx_req.send && (state == tx_idle);

	// Divider restarts on accept so the start bit is exactly one bit long
	assign tick = (clk_cnt == div_w'(`UART_CLK_DIV - 1));

	always_ff @(posedge clk) begin
		if (rst || accept || tick) begin
			clk_cnt <= '0;
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	assign tick_done = tick && (tick_cnt == cnt_w'(1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= tx_idle;
			tx_q     <= 1'b1;
			tick_cnt <= '0;
			bit_cnt  <= '0;
		end else begin
			if (tick && (tick_cnt != '0)) begin
				tick_cnt <= tick_cnt - 1'b1;
			end
			case (state)
				tx_idle: begin
					// Start bit goes out on the next edge
					if (accept) begin
						tx_q     <= 1'b0;
						tick_cnt <= bit_ticks;
						bit_cnt  <= bit_w'(`UART_DATA_BITS);
						state    <= tx_sending;
					end
				end
				tx_sending: begin
					if (tick_done) begin
						if (bit_cnt != '0) begin
							// Next data bit, LSB first
							tx_q     <= data_q[0];
							tick_cnt <= bit_ticks;
							bit_cnt  <= bit_cnt - 1'b1;
						end else begin
							// All data out, line high for the stop bits
							tx_q     <= 1'b1;
							tick_cnt <= stop_count;
							state    <= tx_stop;
						end
					end
				end
				tx_stop: begin
					if (tick_done) begin
						state <= tx_idle;
					end
				end
				default: begin
					tx_q  <= 1'b1;
					state <= tx_idle;
				end
			endcase
		end
	end

	// Byte latched on accept, shifted down as bits leave
	always_ff @(posedge clk) begin
		if (accept) begin
			data_q <= tx_req.data;
		end else if ((state == tx_sending) && tick_done && (bit_cnt != '0)) begin
			data_q <= {1'b0, data_q[`UART_DATA_BITS-1:1]};
		end
	end

	// Pin driven straight from a flop
	assign tx           = tx_q;
	assign transmitting = (state != tx_idle);

endmodule

// File: src/uart.sv
`timescale 1ns/100ps

module uart (
	input  logic                    clk,
	input  logic                    rst,
	// Serial pins, both idle high
	input  logic                    rx,
	output logic                    tx,
	// Parallel side
	input  uart_pkg::tx_req_t       tx_req,
	output uart_pkg::rx_event_t     rx_evt,
	output uart_pkg::line_status_t  status
);

	// Activity flags from each direction
	logic receiving;
	logic transmitting;

	// Receive path
	// Synchronizes rx internally, so the pin can be asynchronous
	uart_rx u_rx (
		.clk       (clk),
		.rst       (rst),
		.rx        (rx),
		.rx_evt    (rx_evt),
		.receiving (receiving)
	);

	// Transmit path
	// Busy requests are dropped, there is no queue
	uart_tx u_tx (
		.clk          (clk),
		.rst          (rst),
		.tx_req       (tx_req),
		.tx           (tx),
		.transmitting (transmitting)
	);

	// Both flags packed for the parallel side
	assign status.receiving    = receiving;
	assign status.transmitting = transmitting;

endmodule

// File: sim/uart_tb.sv
`timescale 1ns/100ps

`include "uart_defs.svh"

module uart_tb;

	import uart_pkg::*;

	// Frame timing in clk cycles
	localparam int bit_clks     = `UART_CLK_DIV * `UART_TICKS_PER_BIT;
	localparam int frame_limit  = 12 * bit_clks;
	localparam int holdoff_clks = `UART_HOLDOFF_TICKS * `UART_CLK_DIV;
	// Shorter than a quarter bit
	localparam int glitch_clks  = `UART_CLK_DIV / 2;
	localparam int drive_delay  = 1;

	logic         clk;
	logic         rst;
	logic         rx_line;
	logic         tx_line;
	// Bit-banged line and loopback select
	logic         drv_line;
	logic         loopback;
	tx_req_t      tx_req;
	rx_event_t    rx_evt;
	line_status_t status;

	// Strobe counters and timestamps kept by the monitor
	int        errors = 0;
	int        cycle = 0;
	int        rx_count = 0;
	int        err_count = 0;
	int        err_cycle = 0;
	int        recv_fall_cycle = 0;
	logic      recv_q = 1'b0;
	rx_event_t last_evt = '0;
	int        base_rx;
	int        base_err;

	// Receiver sees either our own transmitter or the driver
	assign rx_line = loopback ? tx_line : drv_line;

	uart u_dut (
		.clk    (clk),
		.rst    (rst),
		.rx     (rx_line),
		.tx     (tx_line),
		.tx_req (tx_req),
		.rx_evt (rx_evt),
		.status (status)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Monitor samples on the falling edge away from DUT updates
	always @(negedge clk) begin
		cycle = cycle + 1;
		if (rx_evt.received === 1'b1) begin
			rx_count = rx_count + 1;
			last_evt = rx_evt;
		end
		if (rx_evt.error === 1'b1) begin
			err_count = err_count + 1;
			err_cycle = cycle;
		end
		if ((recv_q === 1'b1) && (status.receiving === 1'b0)) begin
			recv_fall_cycle = cycle;
		end
		recv_q = status.receiving;
	end

	task automatic check_rx_evt(input string name, input rx_event_t exp, input rx_event_t act);
		if (act !== exp) begin
			$display("FAILED %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_status(input string name, input line_status_t exp,
			input line_status_t act);
		if (act !== exp) begin
			$display("FAILED %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAILED %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("FAILED %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	// One clock and then the drive offset
	task automatic step;
		@(posedge clk);
		#drive_delay;
	endtask

	task automatic apply_reset;
		rst = 1'b1;
		repeat (5) step;
		rst = 1'b0;
	endtask

	task automatic check_reset_state;
		logic stayed_high;
		stayed_high = 1'b1;
		check_bit("tx", 1'b1, tx_line);
		check_status("status", '0, status);
		check_bit("rx_evt.received", 1'b0, rx_evt.received);
		check_bit("rx_evt.error", 1'b0, rx_evt.error);
		// No request yet so the line must stay idle
		repeat (bit_clks) begin
			step;
			if (tx_line !== 1'b1) stayed_high = 1'b0;
		end
		check_bit("tx", 1'b1, stayed_high);
	endtask

	// Single-cycle strobe on the parallel side
	task automatic send_request(input logic [`UART_DATA_BITS-1:0] data);
		step;
		tx_req.send = 1'b1;
		tx_req.data = data;
		step;
		tx_req.send = 1'b0;
	endtask

	task automatic drive_level(input logic level, input int clks);
		drv_line = level;
		repeat (clks) step;
	endtask

	// Start bit and data LSB first with one stop bit of the given level
	task automatic drive_frame(input logic [`UART_DATA_BITS-1:0] data, input logic stop_level);
		step;
		drive_level(1'b0, bit_clks);
		for (int i = 0; i < `UART_DATA_BITS; i++) begin
			drive_level(data[i], bit_clks);
		end
		drive_level(stop_level, bit_clks);
		drv_line = 1'b1;
	endtask

	task automatic send_glitch;
		step;
		drive_level(1'b0, glitch_clks);
		drv_line = 1'b1;
	endtask

	// Counts are relative to the start of the case
	task automatic wait_strobes(input int want_rx, input int want_err);
		int i;
		for (i = 0; i < frame_limit; i++) begin
			if ((rx_count - base_rx >= want_rx) && (err_count - base_err >= want_err)) break;
			step;
		end
		if (i == frame_limit) begin
			$display("timeout while waiting for %0d received and %0d error strobes",
				want_rx, want_err);
			errors++;
		end
	endtask

	// Both directions back to idle
	task automatic wait_idle;
		int i;
		for (i = 0; i < frame_limit; i++) begin
			if (status === '0) break;
			step;
		end
		if (i == frame_limit) begin
			$display("timeout while waiting for both line flags to fall");
			errors++;
		end
	endtask

	task automatic wait_tx_low(output logic found);
		found = 1'b0;
		for (int i = 0; (i < bit_clks) && !found; i++) begin
			if (tx_line === 1'b0) found = 1'b1;
			else step;
		end
		if (!found) begin
			$display("no start bit appeared on tx after the request");
			errors++;
		end
	endtask

	// Sample tx mid-bit from the falling start edge
	task automatic check_frame_shape(input logic [`UART_DATA_BITS-1:0] data);
		logic found;
		logic exp;
		send_request(data);
		wait_tx_low(found);
		if (found) begin
			repeat (bit_clks / 2) step;
			for (int i = 0; i < `UART_DATA_BITS + 3; i++) begin
				if (i == 0) exp = 1'b0;
				else if (i <= `UART_DATA_BITS) exp = data[i-1];
				else exp = 1'b1;
				check_bit($sformatf("tx bit %0d", i), exp, tx_line);
				if (i < `UART_DATA_BITS + 2) repeat (bit_clks) step;
			end
			// Still busy in the second stop bit and idle once 11 bit periods are over
			check_bit("status.transmitting", 1'b1, status.transmitting);
			repeat (bit_clks / 2) step;
			check_status("status", '0, status);
		end
	endtask

	initial begin
		int                         fd;
		int                         n_read;
		int                         case_num;
		int                         cases_failed;
		int                         errors_before;
		int                         exp_rx;
		int                         held;
		string                      line;
		logic [7:0]                 kind;
		logic [`UART_DATA_BITS-1:0] data;
		logic                       exp_err;
		logic                       stayed_high;
		rx_event_t                  exp_evt;
		void'($urandom(32'h6e09_8d0b));
		case_num = 0;
		cases_failed = 0;
		rst = 1'b1;
		tx_req = '0;
		drv_line = 1'b1;
		loopback = 1'b0;
		apply_reset;
		check_reset_state;
		fd = $fopen("sim/uart_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open the case file sim/uart_cases.txt");
			errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				// Skip comments and blank lines
				if ((line.len() < 5) || (line.getc(0) == "#")) continue;
				n_read = $sscanf(line, "%c %h %h", kind, data, exp_err);
				if (n_read != 3) begin
					$display("unreadable case line %s", line);
					errors++;
					continue;
				end
				case_num++;
				errors_before = errors;
				base_rx = rx_count;
				base_err = err_count;
				exp_rx = ((kind == "R") || (kind == "F")) ? 0 : 1;
				case (kind)
					"R": begin
						loopback = 1'b0;
						apply_reset;
						check_reset_state;
					end
					"T": begin
						loopback = 1'b1;
						check_frame_shape(data);
						wait_strobes(1, 0);
					end
					"L": begin
						loopback = 1'b1;
						send_request(data);
						wait_strobes(1, 0);
					end
					"D": begin
						loopback = 1'b0;
						drive_frame(data, 1'b1);
						wait_strobes(1, 0);
					end
					"F": begin
						// Low stop bit followed by the holdoff
						loopback = 1'b0;
						drive_frame(data, 1'b0);
						wait_strobes(0, 1);
					end
					"G": begin
						loopback = 1'b0;
						send_glitch;
						wait_strobes(0, 1);
						wait_idle;
						drive_frame(data, 1'b1);
						wait_strobes(1, 1);
					end
					"B": begin
						// Second byte must be dropped while busy
						loopback = 1'b1;
						send_request(data);
						repeat (bit_clks) step;
						check_bit("status.transmitting", 1'b1, status.transmitting);
						send_request(~data);
						wait_strobes(1, 0);
						wait_idle;
						stayed_high = 1'b1;
						repeat (frame_limit) begin
							step;
							if ((tx_line !== 1'b1) || (status.transmitting !== 1'b0)) begin
								stayed_high = 1'b0;
							end
						end
						check_bit("tx", 1'b1, stayed_high);
					end
					default: begin
						$display("unknown case kind %c", kind);
						errors++;
					end
				endcase
				wait_idle;
				repeat (1 + $urandom % 16) step;
				// Receiver stays busy through the whole holdoff after a bad stop bit
				if (kind == "F") begin
					held = recv_fall_cycle - err_cycle;
					if (held < holdoff_clks) begin
						$display("receiving flag fell %0d cycles after the error, before the holdoff",
							held);
						errors++;
					end
				end
				check_count("received strobes", exp_rx, rx_count - base_rx);
				check_count("error strobes", int'(exp_err), err_count - base_err);
				if (exp_rx == 1) begin
					exp_evt.received = 1'b1;
					exp_evt.error = 1'b0;
					exp_evt.data = data;
					check_rx_evt("rx_evt", exp_evt, last_evt);
				end
				if (errors != errors_before) cases_failed++;
				$display("case %0d kind %c data %h %s", case_num, kind, data,
					(errors == errors_before) ? "ok" : "wrong");
			end
			$fclose(fd);
		end
		$display("cases %0d, passed %0d, failed %0d, errors %0d",
			case_num, case_num - cases_failed, cases_failed, errors);
		if ((errors == 0) && (case_num > 0)) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: sim/uart_cases.txt
# kind data expect_error, data in hex
# kinds R reset, T tx frame shape, L loopback, D driven frame, F low stop, G start glitch, B busy drop
R 00 0
T a5 0
T 01 0
T 80 0
L 00 0
L ff 0
L 5a 0
L 3c 0
D 96 0
D 7e 0
F c3 1
F 00 1
G 69 1
L 81 0
B 42 0
B e7 0
F ff 1
G 11 1
D 01 0
R 00 0
L 24 0
T 5c 0
D 55 0
B 0f 0

// File: uart.f
+incdir+src
src/uart_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/uart.sv
sim/uart_tb.sv

// File: Makefile
# Verilator build and run for the UART testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= uart_tb
FILELIST  ?= uart.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
FAIL_MSG  ?= Testbench failed
PASS_MSG  ?= Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, log to $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

# The log decides the result, not the simulator exit status
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
